//--- Bender.yml
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_ram.sv
  - dcache_plru.sv
  - dcache_lookup.sv
  - dcache_miss_ctrl.sv
  - dcache_axi_burst.sv
  - dcache_top.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - tb_axi_mem.sv
      - tb_dcache.sv

//--- dcache_axi_burst.sv
`timescale 1ns/1ns

module dcache_axi_burst (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rd_start,
    input  logic [dcache_pkg::addr_w-1:0] rd_line_addr,
    input  logic                          wr_start,
    input  logic [dcache_pkg::addr_w-1:0] wr_line_addr,
    output logic                          rd_done,
    output logic                          wr_done,
    output logic                          beat_we,
    output dcache_pkg::word_sel_t         beat_word,
    output dcache_pkg::word_t             beat_data,
    output dcache_pkg::word_sel_t         wb_word,
    input  dcache_pkg::word_t             wb_data,
    output logic [dcache_pkg::addr_w-1:0] araddr,
    output logic [3:0]                    arlen,
    output logic [2:0]                    arsize,
    output logic                          arvalid,
    input  logic                          arready,
    input  dcache_pkg::word_t             rdata,
    input  logic                          rlast,
    input  logic                          rvalid,
    output logic                          rready,
    output logic [dcache_pkg::addr_w-1:0] awaddr,
    output logic [3:0]                    awlen,
    output logic [2:0]                    awsize,
    output logic                          awvalid,
    input  logic                          awready,
    output dcache_pkg::word_t             wdata,
    output logic [3:0]                    wstrb,
    output logic                          wlast,
    output logic                          wvalid,
    input  logic                          wready,
    input  logic                          bvalid,
    output logic                          bready
);
    import dcache_pkg::*;

    logic      rd_act;   // read address accepted
    logic      w_act;    // write address accepted
    word_sel_t rcnt;
    word_sel_t wcnt;

    assign arlen  = burst_len;
    assign arsize = word_size;
    assign awlen  = burst_len;
    assign awsize = word_size;
    assign wstrb  = 4'hf;  // always full lines

    assign rready    = rd_act;
    assign beat_we   = rvalid & rready;
    assign beat_word = rcnt;
    assign beat_data = rdata;
    assign rd_done   = beat_we & rlast;

    assign wvalid  = w_act;
    assign wb_word = wcnt;
    assign wdata   = wb_data;
    assign wlast   = (wcnt == word_sel_t'(line_words - 1));
    assign wr_done = bvalid & bready;

    always_ff @(posedge clk) begin
        if (rd_start) araddr <= rd_line_addr;
        if (wr_start) awaddr <= wr_line_addr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
            rd_act  <= 1'b0;
            rcnt    <= '0;
        end else begin
            if (rd_start) arvalid <= 1'b1;
            else if (arvalid & arready) begin
                arvalid <= 1'b0;
                rd_act  <= 1'b1;
            end
            if (beat_we) rcnt <= rcnt + 1'b1;  // wraps to 0 after beat 8
            if (rd_done) rd_act <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid <= 1'b0;
            w_act   <= 1'b0;
            bready  <= 1'b0;
            wcnt    <= '0;
        end else begin
            if (wr_start) awvalid <= 1'b1;
            else if (awvalid & awready) begin
                awvalid <= 1'b0;
                w_act   <= 1'b1;
            end
            if (wvalid & wready) begin
                wcnt <= wcnt + 1'b1;
                if (wlast) begin
                    w_act  <= 1'b0;
                    bready <= 1'b1;  // wait for the response
                end
            end
            if (wr_done) bready <= 1'b0;
        end
    end

endmodule

//--- dcache_lookup.sv
`timescale 1ns/1ns

module dcache_lookup (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  logic [dcache_pkg::addr_w-1:0] req_addr,
    input  logic [3:0]                    req_wen,
    input  dcache_pkg::word_t             req_wdata,
    output dcache_pkg::word_t             req_rdata,
    output logic                          hit,
    output dcache_pkg::way_t              hit_way,
    input  dcache_pkg::way_t              victim_way,
    output logic                          victim_dirty,
    output dcache_pkg::tag_t              victim_tag,
    input  logic                          beat_we,
    input  dcache_pkg::word_sel_t         beat_word,
    input  dcache_pkg::word_t             beat_data,
    input  dcache_pkg::word_sel_t         wb_word,
    output dcache_pkg::word_t             wb_data
);
    import dcache_pkg::*;

    logic [way_num-1:0] valid_q [2**index_w];
    logic [way_num-1:0] dirty_q [2**index_w];
    logic [index_w-1:0] idx;
    tag_t               tag;
    word_sel_t          word;
    tag_t               tag_rd [way_num];
    word_t              data_rd [way_num];
    logic [way_num-1:0] hit_mask;
    logic [index_w+word_sel_w-1:0] data_raddr;
    logic [index_w+word_sel_w-1:0] data_waddr;
    word_t              merged;
    logic               store_hit;
    logic               last_beat;

    assign tag  = req_addr[addr_w-1 -: tag_w];
    assign idx  = req_addr[offset_w +: index_w];
    assign word = req_addr[offset_w-1 -: word_sel_w];

    assign hit       = req_valid & (|hit_mask);
    assign store_hit = hit & (|req_wen);
    assign last_beat = beat_we & (beat_word == word_sel_t'(line_words - 1));

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < way_num; w++) begin
            if (hit_mask[w]) hit_way = way_t'(w);
        end
    end

    // no hit while a miss is in flight, so the read port serves write-back then
    assign data_raddr = {idx, hit ? word : wb_word};
    assign data_waddr = {idx, beat_we ? beat_word : word};

    assign req_rdata = data_rd[hit_way];
    assign wb_data   = data_rd[victim_way];

    always_comb begin
        merged = data_rd[hit_way];
        for (int b = 0; b < 4; b++) begin
            if (req_wen[b]) merged[8*b +: 8] = req_wdata[8*b +: 8];  // byte lane merge
        end
    end

    assign victim_dirty = dirty_q[idx][victim_way];
    assign victim_tag   = tag_rd[victim_way];

    for (genvar w = 0; w < way_num; w++) begin : g_way
        assign hit_mask[w] = valid_q[idx][w] & (tag_rd[w] == tag);

        dcache_ram #(.entry_t(tag_t), .depth(2**index_w)) tag_ram_i (
            .clk   (clk),
            .we    (last_beat & (victim_way == way_t'(w))),
            .waddr (idx),
            .wdata (tag),
            .raddr (idx),
            .rdata (tag_rd[w])
        );

        dcache_ram #(.entry_t(word_t), .depth(2**index_w * line_words)) data_ram_i (
            .clk   (clk),
            .we    ((beat_we & (victim_way == way_t'(w))) | (store_hit & hit_mask[w])),
            .waddr (data_waddr),
            .wdata (beat_we ? beat_data : merged),
            .raddr (data_raddr),
            .rdata (data_rd[w])
        );
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < 2**index_w; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (last_beat) begin
            valid_q[idx][victim_way] <= 1'b1;  // line now complete
            dirty_q[idx][victim_way] <= 1'b0;
        end else if (store_hit) begin
            dirty_q[idx][hit_way] <= 1'b1;
        end
    end

endmodule

//--- dcache_miss_ctrl.sv
`timescale 1ns/1ns

module dcache_miss_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  logic [dcache_pkg::addr_w-1:0] req_addr,
    input  logic                          hit,
    input  dcache_pkg::way_t              hit_way,
    input  logic                          victim_dirty,
    input  dcache_pkg::tag_t              victim_tag,
    output dcache_pkg::way_t              victim_way,
    output logic                          req_stall,
    output logic                          rd_start,
    output logic [dcache_pkg::addr_w-1:0] rd_line_addr,
    output logic                          wr_start,
    output logic [dcache_pkg::addr_w-1:0] wr_line_addr,
    input  logic                          rd_done,
    input  logic                          wr_done
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {st_idle, st_wb, st_refill} state_t;

    state_t state;
    way_t   plru_victim;
    way_t   victim_q;
    logic   idle;

    assign idle = (state == st_idle);

    dcache_plru plru_i (
        .clk        (clk),
        .rst        (rst),
        .index      (req_addr[offset_w +: index_w]),
        .touch      (hit & idle),
        .touch_way  (hit_way),
        .victim_way (plru_victim)
    );

    // victim held steady once the miss is taken
    always_ff @(posedge clk) begin
        if (idle) victim_q <= plru_victim;
    end

    assign victim_way   = idle ? plru_victim : victim_q;
    assign req_stall    = req_valid & (~idle | ~hit);
    assign rd_line_addr = {req_addr[addr_w-1:offset_w], {offset_w{1'b0}}};
    assign wr_line_addr = {victim_tag, req_addr[offset_w +: index_w], {offset_w{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            rd_start <= 1'b0;
            wr_start <= 1'b0;
        end else begin
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            case (state)
                st_idle: begin
                    if (req_valid & ~hit) begin
                        if (victim_dirty) begin
                            state    <= st_wb;      // flush victim first
                            wr_start <= 1'b1;
                        end else begin
                            state    <= st_refill;
                            rd_start <= 1'b1;
                        end
                    end
                end
                st_wb: begin
                    if (wr_done) begin
                        state    <= st_refill;
                        rd_start <= 1'b1;
                    end
                end
                st_refill: if (rd_done) state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

endmodule

//--- dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int addr_w     = 32;
    localparam int data_w     = 32;
    localparam int offset_w   = 5;   // byte offset within a line
    localparam int index_w    = 4;   // 16 sets
    localparam int tag_w      = 23;
    localparam int way_num    = 4;
    localparam int way_w      = 2;
    localparam int line_words = 8;
    localparam int word_sel_w = 3;

    // axi burst codes for a full line
    localparam logic [3:0] burst_len = 4'd7;  // 8 beats
    localparam logic [2:0] word_size = 3'd2;  // 4 bytes per beat

    typedef logic [tag_w-1:0]      tag_t;
    typedef logic [data_w-1:0]     word_t;
    typedef logic [way_w-1:0]      way_t;
    typedef logic [word_sel_w-1:0] word_sel_t;

endpackage

//--- dcache_plru.sv
`timescale 1ns/1ns

module dcache_plru (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [dcache_pkg::index_w-1:0] index,
    input  logic                          touch,
    input  dcache_pkg::way_t              touch_way,
    output dcache_pkg::way_t              victim_way
);
    import dcache_pkg::*;

    logic [2:0] tree_q [2**index_w];  // bit0 half, bit1 ways 0/1, bit2 ways 2/3
    logic [2:0] cur;

    assign cur = tree_q[index];

    // follow the tree down to the leaf
    assign victim_way = {cur[0], cur[0] ? cur[2] : cur[1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < 2**index_w; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch) begin
            tree_q[index][0] <= ~touch_way[1];  // point to the other half
            if (touch_way[1]) begin
                tree_q[index][2] <= ~touch_way[0];
            end else begin
                tree_q[index][1] <= ~touch_way[0];
            end
        end
    end

endmodule

//--- dcache_ram.sv
`timescale 1ns/1ns

module dcache_ram #(
    parameter type entry_t = dcache_pkg::word_t,
    parameter int  depth   = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  entry_t                   wdata,
    input  logic [$clog2(depth)-1:0] raddr,
    output entry_t                   rdata
);

    entry_t mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // async read, addressed by the live request
    assign rdata = mem[raddr];

endmodule

//--- dcache_top.sv
`timescale 1ns/1ns

module dcache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  logic [dcache_pkg::addr_w-1:0] req_addr,
    input  logic [3:0]                    req_wen,
    input  dcache_pkg::word_t             req_wdata,
    output dcache_pkg::word_t             req_rdata,
    output logic                          req_stall,
    output logic [dcache_pkg::addr_w-1:0] araddr,
    output logic [3:0]                    arlen,
    output logic [2:0]                    arsize,
    output logic                          arvalid,
    input  logic                          arready,
    input  dcache_pkg::word_t             rdata,
    input  logic                          rlast,
    input  logic                          rvalid,
    output logic                          rready,
    output logic [dcache_pkg::addr_w-1:0] awaddr,
    output logic [3:0]                    awlen,
    output logic [2:0]                    awsize,
    output logic                          awvalid,
    input  logic                          awready,
    output dcache_pkg::word_t             wdata,
    output logic [3:0]                    wstrb,
    output logic                          wlast,
    output logic                          wvalid,
    input  logic                          wready,
    input  logic                          bvalid,
    output logic                          bready
);
    import dcache_pkg::*;

    logic              hit, victim_dirty;
    way_t              hit_way, victim_way;
    tag_t              victim_tag;
    logic              rd_start, wr_start, rd_done, wr_done;
    logic [addr_w-1:0] rd_line_addr, wr_line_addr;
    logic              beat_we;
    word_sel_t         beat_word, wb_word;
    word_t             beat_data, wb_data;

    dcache_lookup lookup_i (
        .clk, .rst, .req_valid, .req_addr, .req_wen, .req_wdata, .req_rdata,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .beat_we, .beat_word, .beat_data, .wb_word, .wb_data
    );

    dcache_miss_ctrl miss_ctrl_i (
        .clk, .rst, .req_valid, .req_addr, .hit, .hit_way,
        .victim_dirty, .victim_tag, .victim_way, .req_stall,
        .rd_start, .rd_line_addr, .wr_start, .wr_line_addr, .rd_done, .wr_done
    );

    dcache_axi_burst axi_burst_i (
        .clk, .rst, .rd_start, .rd_line_addr, .wr_start, .wr_line_addr,
        .rd_done, .wr_done, .beat_we, .beat_word, .beat_data, .wb_word, .wb_data,
        .araddr, .arlen, .arsize, .arvalid, .arready, .rdata, .rlast, .rvalid, .rready,
        .awaddr, .awlen, .awsize, .awvalid, .awready,
        .wdata, .wstrb, .wlast, .wvalid, .wready, .bvalid, .bready
    );

endmodule

//--- list.f
dcache_pkg.sv
dcache_ram.sv
dcache_plru.sv
dcache_lookup.sv
dcache_miss_ctrl.sv
dcache_axi_burst.sv
dcache_top.sv
tb_clk_gen.sv
tb_axi_mem.sv
tb_dcache.sv

//--- tb_axi_mem.sv
`timescale 1ns/1ns

module tb_axi_mem #(
    parameter logic [31:0] fill_key  = 32'h5a5a_0000,
    parameter int          mem_words = 1024
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rvalid,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid
);

    logic [31:0] mem [mem_words];
    int unsigned lcg_state = 23;

    // ready delay of 0 to 3 cycles
    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'((lcg_state >> 16) & 32'd3);
    endfunction

    // each wait ends 2 ns after an edge
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = i ^ fill_key;  // word address xor key
        end
    end

    initial begin : read_side
        logic [31:0] addr;
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        forever begin
            @(posedge clk);
            #2;
            if (arvalid && !rst) begin
                addr = araddr;
                idle_cycles(next_delay());
                arready = 1'b1;
                @(posedge clk);
                #2;
                arready = 1'b0;
                for (int b = 0; b < 8; b++) begin
                    idle_cycles(next_delay());
                    rvalid = 1'b1;
                    rdata  = mem[addr[11:2] + 10'(b)];
                    rlast  = (b == 7);
                    @(posedge clk);
                    #2;
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                end
            end
        end
    end

    initial begin : write_side
        logic [31:0] addr;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (awvalid && !rst) begin
                addr = awaddr;
                idle_cycles(next_delay());
                awready = 1'b1;
                @(posedge clk);
                #2;
                awready = 1'b0;
                for (int b = 0; b < 8; b++) begin
                    idle_cycles(next_delay());
                    wready = 1'b1;
                    if (wvalid) mem[addr[11:2] + 10'(b)] = wdata;  // data steady in this cycle
                    @(posedge clk);
                    #2;
                    wready = 1'b0;
                end
                idle_cycles(next_delay());
                bvalid = 1'b1;
                @(posedge clk);
                #2;
                bvalid = 1'b0;
            end
        end
    end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int period     = 20,
    parameter int rst_cycles = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        #2 rst = 1'b0;  // released just after the edge
    end

endmodule

//--- tb_dcache.sv
`timescale 1ns/1ns

module tb_dcache;
    import dcache_pkg::*;

    localparam logic [31:0] fill_key   = 32'h5a5a_0000;
    localparam int          mem_words  = 1024;
    localparam int          max_cycles = 2000;

    logic        clk, rst;
    logic        req_valid, req_stall;
    logic [31:0] req_addr;
    logic [3:0]  req_wen;
    word_t       req_wdata, req_rdata;
    logic [31:0] araddr, awaddr, rdata, wdata;
    logic [3:0]  arlen, awlen, wstrb;
    logic [2:0]  arsize, awsize;
    logic        arvalid, arready, rlast, rvalid, rready;
    logic        awvalid, awready, wlast, wvalid, wready, bvalid, bready;

    // reference model
    word_t      ref_mem [mem_words];
    tag_t       model_tag [16][4];
    logic       model_valid [16][4];
    logic       model_dirty [16][4];
    logic [2:0] model_tree [16];

    int cycles, checks, errors, test_errs, tests_run, tests_failed;
    int ar_count, aw_count;
    logic [31:0] last_araddr, last_awaddr;
    logic [3:0]  last_arlen, last_awlen;
    logic [2:0]  last_arsize, last_awsize;
    word_t       wb_data_q [$];
    logic        wb_last_q [$];
    logic [3:0]  wb_strb_q [$];

    tb_clk_gen #(.period(20), .rst_cycles(10)) clk_gen_i (.clk(clk), .rst(rst));

    dcache_top dcache_top_i (.*);

    tb_axi_mem #(.fill_key(fill_key), .mem_words(mem_words)) axi_mem_i (
        .clk, .rst, .araddr, .arvalid, .arready, .rdata, .rlast, .rvalid,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready, .bvalid
    );

    // bus monitor samples mid-cycle where everything is settled
    always @(negedge clk) begin
        if (arvalid && arready) begin
            ar_count++;
            last_araddr = araddr;
            last_arlen  = arlen;
            last_arsize = arsize;
        end
        if (awvalid && awready) begin
            aw_count++;
            last_awaddr = awaddr;
            last_awlen  = awlen;
            last_awsize = awsize;
        end
        if (wvalid && wready) begin
            wb_data_q.push_back(wdata);
            wb_last_q.push_back(wlast);
            wb_strb_q.push_back(wstrb);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("run stopped, no progress after %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR %s got %h expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        checks++;
        assert (cond === 1'b1) else begin
            $display("%s", what);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        errors += test_errs;
        if (test_errs == 0) $display("%s: ok", name);
        else begin
            $display("%s: FAIL, %0d errors", name, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    // walk the tree from the half bit down to one way
    function automatic int tree_victim(input logic [2:0] t);
        if (t[0] == 1'b0) return t[1] ? 1 : 0;
        return t[2] ? 3 : 2;
    endfunction

    // the touched way's path now leads to its neighbours
    function automatic logic [2:0] tree_touch(input logic [2:0] t, input int w);
        logic [2:0] n;
        n = t;
        if (w < 2) begin
            n[0] = 1'b1;      // ways 2/3 next
            n[1] = (w == 0);  // sibling in this half
        end else begin
            n[0] = 1'b0;
            n[2] = (w == 2);
        end
        return n;
    endfunction

    // one request that starts and ends 2 ns after an edge
    task automatic cache_access(input logic [31:0] addr, input logic [3:0] wen, input word_t wd);
        int          set, hw, vw, ar0, aw0;
        tag_t        tg;
        logic        stalled, wb_exp;
        word_t       rd, merged;
        logic [31:0] vline;
        logic [31:0] mask;
        logic [9:0]  wi;
        set = addr[8:5];
        tg  = addr[31:9];
        wi  = addr[11:2];
        hw  = -1;
        for (int w = 0; w < 4; w++) begin
            if (model_valid[set][w] && model_tag[set][w] == tg) hw = w;
        end
        vw     = tree_victim(model_tree[set]);
        wb_exp = (hw < 0) && model_valid[set][vw] && model_dirty[set][vw];
        vline  = {model_tag[set][vw], addr[8:5], 5'b0};
        ar0 = ar_count;
        aw0 = aw_count;
        wb_data_q.delete();
        wb_last_q.delete();
        wb_strb_q.delete();
        req_valid = 1'b1;
        req_addr  = addr;
        req_wen   = wen;
        req_wdata = wd;
        stalled   = 1'b0;
        @(negedge clk);
        while (req_stall) begin
            stalled = 1'b1;
            @(negedge clk);
        end
        rd = req_rdata;
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        req_wen   = 4'h0;
        check_val("req_stall", stalled, hw < 0);
        if (hw >= 0) begin
            check_true("read burst issued on a cache hit", ar_count == ar0);
        end else begin
            check_val("ar_count", ar_count - ar0, 1);
            check_val("araddr", last_araddr, {addr[31:5], 5'b0});
            check_val("arlen", last_arlen, 4'd7);
            check_val("arsize", last_arsize, 3'd2);
            check_val("aw_count", aw_count - aw0, wb_exp ? 1 : 0);
            if (wb_exp) begin
                check_val("awaddr", last_awaddr, vline);
                check_val("awlen", last_awlen, 4'd7);
                check_val("awsize", last_awsize, 3'd2);
                check_val("write beats", wb_data_q.size(), 8);
                for (int b = 0; b < wb_data_q.size() && b < 8; b++) begin
                    check_val("wdata", wb_data_q[b], ref_mem[vline[11:2] + 10'(b)]);
                    check_val("wlast", wb_last_q[b], b == 7);
                    check_val("wstrb", wb_strb_q[b], 4'hf);
                end
            end
            hw = vw;
            model_tag[set][hw]   = tg;
            model_valid[set][hw] = 1'b1;
            model_dirty[set][hw] = 1'b0;
        end
        model_tree[set] = tree_touch(model_tree[set], hw);
        if (wen == 4'h0) begin
            check_val("req_rdata", rd, ref_mem[wi]);
        end else begin
            mask   = {{8{wen[3]}}, {8{wen[2]}}, {8{wen[1]}}, {8{wen[0]}}};  // byte enables
            merged = (ref_mem[wi] & ~mask) | (wd & mask);
            ref_mem[wi]          = merged;
            model_dirty[set][hw] = 1'b1;
        end
    endtask

    initial begin
        req_valid = 1'b0;
        req_addr  = '0;
        req_wen   = 4'h0;
        req_wdata = '0;
        for (int i = 0; i < mem_words; i++) ref_mem[i] = i ^ fill_key;
        for (int s = 0; s < 16; s++) begin
            model_tree[s] = 3'b000;
            for (int w = 0; w < 4; w++) begin
                model_valid[s][w] = 1'b0;
                model_dirty[s][w] = 1'b0;
            end
        end
        wait (rst === 1'b0);
        @(negedge clk);
        check_val("arvalid", arvalid, 1'b0);
        check_val("awvalid", awvalid, 1'b0);
        check_val("wvalid", wvalid, 1'b0);
        check_val("rready", rready, 1'b0);
        check_val("bready", bready, 1'b0);
        check_val("req_stall", req_stall, 1'b0);
        end_test("reset state");
        @(posedge clk);
        #2;
        cache_access(32'h0000_0064, 4'h0, '0);
        end_test("load miss refill");
        cache_access(32'h0000_0070, 4'h0, '0);
        end_test("load hit same line");
        cache_access(32'h0000_0068, 4'b0110, 32'hdead_beef);
        cache_access(32'h0000_0068, 4'h0, '0);
        end_test("partial store hit");
        for (int t = 1; t <= 4; t++) begin
            cache_access((t << 9) | 32'h64, 4'hf, 32'h1000_0000 + t);
            cache_access((t << 9) | 32'h64, 4'h0, '0);
        end
        end_test("plru eviction with write-back");
        cache_access(32'h0000_0068, 4'h0, '0);
        cache_access(32'h0000_0064, 4'h0, '0);
        end_test("reload evicted line");
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
